/* bench/tb_tlu_controller_core.sv */
// testbench for the trigger controller core
// random register, trigger, limit, overflow and soft reset checks against a model
`timescale 1ns/10ps

module tb_tlu_controller_core;
    import tlu_pkg::*;

    logic BUS_CLK = 1'b0;
    logic RST;
    logic [bus_addr_w-1:0] bus_add;
    logic [bus_data_w-1:0] bus_data_in;
    logic bus_rd;
    logic bus_wr;
    logic [bus_data_w-1:0] bus_data_out;
    logic fifo_read;
    logic fifo_empty;
    logic [word_w-1:0] fifo_data;
    logic [trig_w-1:0] trigger;
    logic [trig_w-1:0] trigger_veto;
    logic ext_trigger_enable;
    logic trigger_acknowledge;
    logic trigger_accepted_flag;

    // reference model state
    logic [bus_data_w-1:0] exp_sel;
    logic [bus_data_w-1:0] exp_veto_sel;
    logic [bus_data_w-1:0] exp_inv;
    logic exp_conf;
    reg32_u exp_max;
    reg32_u exp_count;
    logic [2:0][bus_data_w-1:0] exp_preset;    // bytes 8 to 10 waiting for byte 11
    reg32_u exp_latch;
    logic [bus_data_w-1:0] exp_lost;
    reg32_u exp_fifo [$];

    tlu_controller_core i_dut (.*);

    always #4 BUS_CLK = ~BUS_CLK;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_byte(input string name, input logic [bus_data_w-1:0] got,
                                input logic [bus_data_w-1:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic compare_word(input string name, input reg32_u got, input reg32_u exp);
        if (got.word !== exp.word)
            stop_with_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
                                      name, got.word, exp.word));
    endtask

    task automatic next_cycle();
        @(posedge BUS_CLK);
        #1;     // inputs change just after the edge
    endtask

    task automatic bus_write(input int addr, input logic [bus_data_w-1:0] data);
        bus_add = bus_addr_w'(addr);
        bus_data_in = data;
        bus_wr = 1'b1;
        next_cycle();
        bus_wr = 1'b0;
    endtask

    task automatic read_check(input int addr, input logic [bus_data_w-1:0] exp);
        bus_add = bus_addr_w'(addr);
        bus_rd = 1'b1;
        next_cycle();
        bus_rd = 1'b0;
        compare_byte($sformatf("bus_data_out at address %0d", addr), bus_data_out, exp);
    endtask

    function automatic logic [bus_data_w-1:0] model_reg(input int addr);
        logic [bus_data_w-1:0] value;
        value = '0;
        case (addr)
            addr_version: value = tlu_version;
            addr_conf: value[conf_enable_bit] = exp_conf;
            addr_cnt0: value = exp_count.bytes[0];
            addr_cnt1, addr_cnt2, addr_cnt3: value = exp_latch.bytes[addr - 8];
            addr_lost: value = exp_lost;
            addr_trig_sel: value = exp_sel;
            addr_veto_sel: value = exp_veto_sel;
            addr_trig_inv: value = exp_inv;
            addr_max0, addr_max1, addr_max2, addr_max3: value = exp_max.bytes[addr - 16];
            default: value = '0;   // unmapped
        endcase
        return value;
    endfunction

    task automatic read_reg(input int addr);
        read_check(addr, model_reg(addr));
        if (addr == addr_cnt0)
            exp_latch = exp_count;     // whole word captured on the low byte read
    endtask

    task automatic write_reg(input int addr, input logic [bus_data_w-1:0] data);
        bus_write(addr, data);
        case (addr)
            addr_conf: exp_conf = data[conf_enable_bit];
            addr_cnt3: exp_count.word = {data, exp_preset};
            addr_cnt0, addr_cnt1, addr_cnt2: exp_preset[addr - 8] = data;
            addr_trig_sel: exp_sel = data;
            addr_veto_sel: exp_veto_sel = data;
            addr_trig_inv: exp_inv = data;
            addr_max0, addr_max1, addr_max2, addr_max3: exp_max.bytes[addr - 16] = data;
            default: ;
        endcase
    endtask

    // addresses 0 to 19, byte 8 first so 9..11 come from the latch
    task automatic check_registers();
        for (int a = 0; a <= addr_max3; a++)
            read_reg(a);
    endtask

    task automatic reset_model();
        exp_sel = '0;
        exp_veto_sel = veto_sel_default;
        exp_inv = '0;
        exp_conf = 1'b0;
        exp_max = '0;
        exp_count = '0;
        exp_preset = '0;
        exp_latch = '0;
        exp_lost = '0;
        exp_fifo.delete();
    endtask

    function automatic bit accept_expected(input int idx);
        bit enabled;
        bit vetoed;
        bit under_limit;
        enabled = ext_trigger_enable || exp_conf;
        vetoed = |(trigger_veto & exp_veto_sel);
        under_limit = (exp_max.word == '0) || (exp_count.word < exp_max.word);
        return enabled && !vetoed && exp_sel[idx] && under_limit;
    endfunction

    task automatic acknowledge_flag();
        int n;
        repeat ($urandom_range(5, 0)) next_cycle();
        trigger_acknowledge = 1'b1;
        n = 0;
        while (trigger_accepted_flag)
        begin
            next_cycle();
            n++;
            if (n > 20)
                stop_with_error("trigger_accepted_flag stayed high after the acknowledge");
        end
        repeat ($urandom_range(5, 0)) next_cycle();
        trigger_acknowledge = 1'b0;
        next_cycle();     // back to idle
    endtask

    task automatic fire_trigger(input int idx);
        int n;
        bit expect_accept;
        reg32_u w;
        expect_accept = accept_expected(idx);
        trigger[idx] = ~trigger[idx];
        repeat (2) next_cycle();
        trigger[idx] = ~trigger[idx];
        n = 0;
        if (expect_accept)
        begin
            while (!trigger_accepted_flag)
            begin
                next_cycle();
                n++;
                if (n > 20)
                    stop_with_error("trigger_accepted_flag did not rise for an enabled trigger");
            end
            acknowledge_flag();
            w = exp_count;
            w.word[word_w-1] = 1'b1;     // trigger word marker
            if (exp_fifo.size() < fifo_depth)
                exp_fifo.push_back(w);
            else if (exp_lost != 8'hff)
                exp_lost++;     // dropped word
            exp_count.word++;
        end
        else
        begin
            for (n = 0; n < 12; n++)
            begin
                next_cycle();
                if (trigger_accepted_flag)
                    stop_with_error("trigger_accepted_flag rose for a trigger that must be ignored");
            end
        end
    endtask

    task automatic drain_fifo();
        reg32_u head;
        while (exp_fifo.size() > 0)
        begin
            if (fifo_empty)
                stop_with_error("fifo_empty is high while trigger words are still expected");
            head = exp_fifo.pop_front();
            compare_word("fifo_data", fifo_data, head);
            fifo_read = 1'b1;
            next_cycle();
            fifo_read = 1'b0;
        end
        if (!fifo_empty)
            stop_with_error("fifo_empty is low after all expected words were read");
    endtask

    initial
    begin
        int idx;
        reg32_u base;
        void'($urandom(67));
        RST = 1'b1;
        bus_add = '0;
        bus_data_in = '0;
        bus_rd = 1'b0;
        bus_wr = 1'b0;
        fifo_read = 1'b0;
        trigger = '0;
        trigger_veto = '0;
        ext_trigger_enable = 1'b0;
        trigger_acknowledge = 1'b0;
        reset_model();
        repeat (16) @(posedge BUS_CLK);
        #1;
        RST = 1'b0;
        if (trigger_accepted_flag || !fifo_empty)
            stop_with_error("flag or fifo_empty has the wrong level after reset");
        compare_byte("bus_data_out", bus_data_out, '0);
        check_registers();

        // register readback
        for (int a = addr_trig_sel; a <= addr_max3; a++)
            write_reg(a, 8'($urandom));
        check_registers();

        // accepted triggers, conf enable then external enable
        idx = $urandom_range(trig_w - 1, 0);
        write_reg(addr_trig_inv, 8'($urandom));
        trigger = exp_inv;     // idle level
        write_reg(addr_trig_sel, 8'(1 << idx));
        for (int a = addr_max0; a <= addr_max3; a++)
            write_reg(a, '0);
        repeat (8) next_cycle();
        write_reg(addr_conf, 8'(1 << conf_enable_bit));
        repeat (3) fire_trigger(idx);
        write_reg(addr_conf, '0);
        ext_trigger_enable = 1'b1;
        repeat (2) fire_trigger(idx);
        drain_fifo();
        check_registers();

        // veto, disable and unselected input
        write_reg(addr_veto_sel, 8'hff);
        trigger_veto = 8'(1 << $urandom_range(trig_w - 1, 0));
        repeat (6) next_cycle();
        fire_trigger(idx);
        trigger_veto = '0;
        repeat (6) next_cycle();
        ext_trigger_enable = 1'b0;
        fire_trigger(idx);
        ext_trigger_enable = 1'b1;
        fire_trigger((idx + 1) % trig_w);
        fire_trigger(idx);
        drain_fifo();

        // counter preset after a low byte read, upper bytes stay latched
        read_reg(addr_cnt0);
        base.word = 32'h0101_0100 | ($urandom % 32'h1000_0000);   // upper bytes nonzero
        for (int a = addr_cnt0; a <= addr_cnt3; a++)
            write_reg(a, base.bytes[a - 8]);
        for (int a = addr_cnt1; a <= addr_cnt3; a++)
            read_reg(a);
        check_registers();
        base.word = base.word + 3;     // limit three counts above the preset
        for (int a = addr_max0; a <= addr_max3; a++)
            write_reg(a, base.bytes[a - 16]);
        repeat (5) fire_trigger(idx);
        drain_fifo();
        check_registers();
        for (int a = addr_max0; a <= addr_max3; a++)
            write_reg(a, '0);

        // overflow with no reads
        repeat (fifo_depth + $urandom_range(4, 1)) fire_trigger(idx);
        check_registers();
        drain_fifo();

        // soft reset with a word left in the FIFO
        fire_trigger(idx);
        ext_trigger_enable = 1'b0;
        bus_write(addr_version, 8'($urandom));
        reset_model();
        next_cycle();
        if (!fifo_empty)
            stop_with_error("fifo_empty is low after a soft reset");
        check_registers();

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* bench/tlu_core_checker.sv */
// handshake and output FIFO assertions for the trigger controller core
`timescale 1ns/10ps

module tlu_core_checker (
    input logic BUS_CLK,
    input logic core_rst,
    input logic trigger_accepted_flag,
    input logic trigger_acknowledge,
    input logic fifo_empty,
    input logic fifo_full
);

    // new flag only after the acknowledge went low
    flag_rise_ack_low: assert property (@(posedge BUS_CLK) disable iff (core_rst)
        $rose(trigger_accepted_flag) |-> !$past(trigger_acknowledge))
        else $error("flag rose while the acknowledge was high");

    flag_hold: assert property (@(posedge BUS_CLK) disable iff (core_rst)
        trigger_accepted_flag && !trigger_acknowledge |=> trigger_accepted_flag)
        else $error("flag dropped before the acknowledge");

    empty_not_full: assert property (@(posedge BUS_CLK) disable iff (core_rst)
        !(fifo_empty && fifo_full))
        else $error("fifo empty and full at once");

endmodule

bind tlu_controller_core tlu_core_checker i_checker (
    .BUS_CLK(BUS_CLK),
    .core_rst(core_rst),
    .trigger_accepted_flag(trigger_accepted_flag),
    .trigger_acknowledge(trigger_acknowledge),
    .fifo_empty(fifo_empty),
    .fifo_full(i_data_fifo.full)
);

/* logic/tlu_cfg_if.sv */
// configuration bundle from the register bank to the trigger path
`timescale 1ns/10ps

interface tlu_cfg_if;
    import tlu_pkg::*;

    logic [trig_w-1:0] trig_sel;     // trigger input select
    logic [trig_w-1:0] trig_inv;     // trigger input invert
    logic [trig_w-1:0] veto_sel;     // veto input select
    logic conf_enable;
    reg32_u count_max;               // zero means no limit

    modport bank (
        output trig_sel,
        output trig_inv,
        output veto_sel,
        output conf_enable,
        output count_max
    );

    modport path (
        input trig_sel,
        input trig_inv,
        input veto_sel,
        input conf_enable,
        input count_max
    );

endinterface

/* logic/tlu_controller_core.sv */
// trigger controller core top level
// register bank, input stage, counter, handshake FSM and output FIFO
`timescale 1ns/10ps

module tlu_controller_core (
    input logic BUS_CLK,
    input logic RST,
    input logic [tlu_pkg::bus_addr_w-1:0] bus_add,
    input logic [tlu_pkg::bus_data_w-1:0] bus_data_in,
    input logic bus_rd,
    input logic bus_wr,
    output logic [tlu_pkg::bus_data_w-1:0] bus_data_out,
    input logic fifo_read,
    output logic fifo_empty,
    output logic [tlu_pkg::word_w-1:0] fifo_data,
    input logic [tlu_pkg::trig_w-1:0] trigger,
    input logic [tlu_pkg::trig_w-1:0] trigger_veto,
    input logic ext_trigger_enable,
    input logic trigger_acknowledge,
    output logic trigger_accepted_flag
);
    import tlu_pkg::*;

    logic core_rst;             // bus reset or soft reset
    logic cnt_set;
    reg32_u cnt_set_value;
    logic trig_pulse;
    logic veto;
    logic accept;
    reg32_u count;
    logic limit_reached;
    logic [bus_data_w-1:0] lost_count;

    tlu_cfg_if i_cfg ();

    tlu_reg_bank i_reg_bank (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .bus_add(bus_add),
        .bus_data_in(bus_data_in),
        .bus_rd(bus_rd),
        .bus_wr(bus_wr),
        .bus_data_out(bus_data_out),
        .count(count),
        .lost_count(lost_count),
        .cfg(i_cfg.bank),
        .core_rst(core_rst),
        .cnt_set(cnt_set),
        .cnt_set_value(cnt_set_value)
    );

    tlu_trigger_input i_trigger_input (
        .BUS_CLK(BUS_CLK),
        .core_rst(core_rst),
        .trigger(trigger),
        .trigger_veto(trigger_veto),
        .cfg(i_cfg.path),
        .trig_pulse(trig_pulse),
        .veto(veto)
    );

    tlu_trigger_counter i_trigger_counter (
        .BUS_CLK(BUS_CLK),
        .core_rst(core_rst),
        .cnt_set(cnt_set),
        .cnt_set_value(cnt_set_value),
        .accept(accept),
        .cfg(i_cfg.path),
        .count(count),
        .limit_reached(limit_reached)
    );

    tlu_trigger_fsm i_trigger_fsm (
        .BUS_CLK(BUS_CLK),
        .core_rst(core_rst),
        .trig_pulse(trig_pulse),
        .veto(veto),
        .ext_trigger_enable(ext_trigger_enable),
        .limit_reached(limit_reached),
        .cfg(i_cfg.path),
        .trigger_acknowledge(trigger_acknowledge),
        .trigger_accepted_flag(trigger_accepted_flag),
        .accept(accept)
    );

    tlu_data_fifo i_data_fifo (
        .BUS_CLK(BUS_CLK),
        .core_rst(core_rst),
        .accept(accept),
        .count(count),
        .fifo_read(fifo_read),
        .fifo_empty(fifo_empty),
        .fifo_data(fifo_data),
        .lost_count(lost_count)
    );

endmodule

/* logic/tlu_data_fifo.sv */
// trigger word output FIFO, first word fall through
// drops words when full and counts them with saturation
`timescale 1ns/10ps

module tlu_data_fifo (
    input logic BUS_CLK,
    input logic core_rst,
    input logic accept,
    input tlu_pkg::reg32_u count,
    input logic fifo_read,
    output logic fifo_empty,
    output logic [tlu_pkg::word_w-1:0] fifo_data,
    output logic [tlu_pkg::bus_data_w-1:0] lost_count
);
    import tlu_pkg::*;

    localparam int ptr_w = $clog2(fifo_depth);

    logic [word_w-1:0] mem [fifo_depth];
    logic [ptr_w:0] wr_ptr;     // extra bit tells full from empty
    logic [ptr_w:0] rd_ptr;
    logic full;
    logic push;
    logic pop;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) && (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);
    assign push = accept && !full;
    assign pop = fifo_read && !fifo_empty;

    always_ff @(posedge BUS_CLK)
    begin
        if (push)
            mem[wr_ptr[ptr_w-1:0]] <= trig_word_flag | {1'b0, count.word[word_w-2:0]};
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign fifo_data = mem[rd_ptr[ptr_w-1:0]];     // head

    // saturates at 255
    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            lost_count <= '0;
        else if (accept && full && (lost_count != '1))
            lost_count <= lost_count + 1'b1;
    end

endmodule

/* logic/tlu_pkg.sv */
// trigger controller shared definitions
// register map, widths, defaults and the byte/word register view
package tlu_pkg;

    localparam int bus_addr_w = 16;
    localparam int bus_data_w = 8;
    localparam int trig_w = 8;       // trigger and veto inputs
    localparam int word_w = 32;
    localparam int fifo_depth = 8;

    localparam logic [bus_data_w-1:0] tlu_version = 8'd6;

    // register addresses
    localparam logic [bus_addr_w-1:0] addr_version = 16'd0;  // write = soft reset
    localparam logic [bus_addr_w-1:0] addr_conf = 16'd1;
    localparam logic [bus_addr_w-1:0] addr_cnt0 = 16'd8;     // read latches full count
    localparam logic [bus_addr_w-1:0] addr_cnt1 = 16'd9;
    localparam logic [bus_addr_w-1:0] addr_cnt2 = 16'd10;
    localparam logic [bus_addr_w-1:0] addr_cnt3 = 16'd11;    // write presets counter
    localparam logic [bus_addr_w-1:0] addr_lost = 16'd12;
    localparam logic [bus_addr_w-1:0] addr_trig_sel = 16'd13;
    localparam logic [bus_addr_w-1:0] addr_veto_sel = 16'd14;
    localparam logic [bus_addr_w-1:0] addr_trig_inv = 16'd15;
    localparam logic [bus_addr_w-1:0] addr_max0 = 16'd16;
    localparam logic [bus_addr_w-1:0] addr_max1 = 16'd17;
    localparam logic [bus_addr_w-1:0] addr_max2 = 16'd18;
    localparam logic [bus_addr_w-1:0] addr_max3 = 16'd19;

    localparam int conf_enable_bit = 3;

    localparam logic [trig_w-1:0] veto_sel_default = '1;     // all vetoes active
    localparam logic [word_w-1:0] trig_word_flag = 32'h8000_0000;

    // handshake FSM encoding
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_wait_ack_high = 2'd1;
    localparam logic [1:0] st_wait_ack_low = 2'd2;

    // byte view for the bus, word view for counting
    typedef union packed {
        logic [3:0][bus_data_w-1:0] bytes;
        logic [word_w-1:0] word;
    } reg32_u;

endpackage

/* logic/tlu_reg_bank.sv */
// trigger controller register bank
// byte-wide bus registers, soft reset, counter read latch and read mux
`timescale 1ns/10ps

module tlu_reg_bank (
    input logic BUS_CLK,
    input logic RST,
    input logic [tlu_pkg::bus_addr_w-1:0] bus_add,
    input logic [tlu_pkg::bus_data_w-1:0] bus_data_in,
    input logic bus_rd,
    input logic bus_wr,
    output logic [tlu_pkg::bus_data_w-1:0] bus_data_out,
    input tlu_pkg::reg32_u count,
    input logic [tlu_pkg::bus_data_w-1:0] lost_count,
    tlu_cfg_if.bank cfg,
    output logic core_rst,
    output logic cnt_set,
    output tlu_pkg::reg32_u cnt_set_value
);
    import tlu_pkg::*;

    logic soft_rst_q;
    logic [2:0][bus_data_w-1:0] cnt_preset;   // bytes 8 to 10
    reg32_u cnt_latch;
    logic [bus_data_w-1:0] rd_mux;

    // write to address 0 gives a one cycle reset
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            soft_rst_q <= 1'b0;
        else
            soft_rst_q <= bus_wr && (bus_add == addr_version);
    end

    assign core_rst = RST | soft_rst_q;

    // preset takes bytes 8..10 plus the byte written now
    assign cnt_set = bus_wr && (bus_add == addr_cnt3);
    assign cnt_set_value.word = {bus_data_in, cnt_preset[2], cnt_preset[1], cnt_preset[0]};

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            cfg.conf_enable <= 1'b0;
            cfg.trig_sel <= '0;
            cfg.veto_sel <= veto_sel_default;
            cfg.trig_inv <= '0;
            cfg.count_max <= '0;
            cnt_preset <= '0;
        end
        else if (bus_wr)
        begin
            case (bus_add)
                addr_conf: cfg.conf_enable <= bus_data_in[conf_enable_bit];
                addr_cnt0: cnt_preset[0] <= bus_data_in;
                addr_cnt1: cnt_preset[1] <= bus_data_in;
                addr_cnt2: cnt_preset[2] <= bus_data_in;
                addr_trig_sel: cfg.trig_sel <= bus_data_in;
                addr_veto_sel: cfg.veto_sel <= bus_data_in;
                addr_trig_inv: cfg.trig_inv <= bus_data_in;
                addr_max0: cfg.count_max.bytes[0] <= bus_data_in;
                addr_max1: cfg.count_max.bytes[1] <= bus_data_in;
                addr_max2: cfg.count_max.bytes[2] <= bus_data_in;
                addr_max3: cfg.count_max.bytes[3] <= bus_data_in;
                default: ;
            endcase
        end
    end

    // snapshot on low byte read keeps the upper bytes consistent
    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            cnt_latch <= '0;
        else if (bus_rd && (bus_add == addr_cnt0))
            cnt_latch <= count;
    end

    always_comb
    begin
        rd_mux = '0;
        case (bus_add)
            addr_version: rd_mux = tlu_version;
            addr_conf: rd_mux[conf_enable_bit] = cfg.conf_enable;
            addr_cnt0: rd_mux = count.bytes[0];       // live value
            addr_cnt1: rd_mux = cnt_latch.bytes[1];
            addr_cnt2: rd_mux = cnt_latch.bytes[2];
            addr_cnt3: rd_mux = cnt_latch.bytes[3];
            addr_lost: rd_mux = lost_count;
            addr_trig_sel: rd_mux = cfg.trig_sel;
            addr_veto_sel: rd_mux = cfg.veto_sel;
            addr_trig_inv: rd_mux = cfg.trig_inv;
            addr_max0: rd_mux = cfg.count_max.bytes[0];
            addr_max1: rd_mux = cfg.count_max.bytes[1];
            addr_max2: rd_mux = cfg.count_max.bytes[2];
            addr_max3: rd_mux = cfg.count_max.bytes[3];
            default: rd_mux = '0;
        endcase
    end

    // read data holds until the next read
    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            bus_data_out <= '0;
        else if (bus_rd)
            bus_data_out <= rd_mux;
    end

endmodule

/* logic/tlu_trigger_counter.sv */
// trigger counter with bus preset and maximum count compare
`timescale 1ns/10ps

module tlu_trigger_counter (
    input logic BUS_CLK,
    input logic core_rst,
    input logic cnt_set,
    input tlu_pkg::reg32_u cnt_set_value,
    input logic accept,
    tlu_cfg_if.path cfg,
    output tlu_pkg::reg32_u count,
    output logic limit_reached
);
    import tlu_pkg::*;

    logic at_limit;

    // preset wins over an accept in the same cycle
    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            count <= '0;
        else if (cnt_set)
            count <= cnt_set_value;
        else if (accept)
            count.word <= count.word + 1'b1;
    end

    // a zero maximum disables the limit
    assign at_limit = (cfg.count_max.word != '0) && (count.word >= cfg.count_max.word);

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            limit_reached <= 1'b0;
        else
            limit_reached <= at_limit;
    end

endmodule

/* logic/tlu_trigger_fsm.sv */
// trigger acceptance FSM
// accepts a trigger pulse and runs the four phase flag/acknowledge handshake
`timescale 1ns/10ps

module tlu_trigger_fsm (
    input logic BUS_CLK,
    input logic core_rst,
    input logic trig_pulse,
    input logic veto,
    input logic ext_trigger_enable,
    input logic limit_reached,
    tlu_cfg_if.path cfg,
    input logic trigger_acknowledge,
    output logic trigger_accepted_flag,
    output logic accept
);
    import tlu_pkg::*;

    logic [1:0] state;
    logic enabled;
    logic take;

    assign enabled = ext_trigger_enable | cfg.conf_enable;

    // ack must be low before a new flag may rise
    assign take = trig_pulse && enabled && !veto && !limit_reached && !trigger_acknowledge;

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            state <= st_idle;
            accept <= 1'b0;
        end
        else
        begin
            accept <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (take)
                    begin
                        state <= st_wait_ack_high;
                        accept <= 1'b1;     // count and FIFO write
                    end
                end
                st_wait_ack_high:
                begin
                    if (trigger_acknowledge)
                        state <= st_wait_ack_low;
                end
                st_wait_ack_low:
                begin
                    if (!trigger_acknowledge)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // flag is high until the acknowledge arrives
    assign trigger_accepted_flag = (state == st_wait_ack_high);

endmodule

/* logic/tlu_trigger_input.sv */
// trigger and veto input stage
// masking, three stage synchronizer and rising edge detect on the trigger
`timescale 1ns/10ps

module tlu_trigger_input (
    input logic BUS_CLK,
    input logic core_rst,
    input logic [tlu_pkg::trig_w-1:0] trigger,
    input logic [tlu_pkg::trig_w-1:0] trigger_veto,
    tlu_cfg_if.path cfg,
    output logic trig_pulse,
    output logic veto
);
    import tlu_pkg::*;

    logic trig_or;
    logic veto_or;
    logic [1:0] sync_1;     // bit 0 trigger, bit 1 veto
    logic [1:0] sync_2;
    logic [1:0] sync_3;
    logic trig_last;        // edge stage

    assign trig_or = |((trigger ^ cfg.trig_inv) & cfg.trig_sel);
    assign veto_or = |(trigger_veto & cfg.veto_sel);

    // inputs are asynchronous to BUS_CLK
    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            sync_1 <= '0;
            sync_2 <= '0;
            sync_3 <= '0;
            trig_last <= 1'b0;
        end
        else
        begin
            sync_1 <= {veto_or, trig_or};
            sync_2 <= sync_1;
            sync_3 <= sync_2;
            trig_last <= sync_3[0];
        end
    end

    assign trig_pulse = sync_3[0] & ~trig_last;
    assign veto = sync_3[1];    // level, not edge

endmodule

/* run_sim.sh */
#!/bin/sh
# compile with Verilator and run, exit status follows the testbench
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f tlu_controller_core.f \
    --top-module tb_tlu_controller_core -o tb_sim &&
./obj_dir/tb_sim || exit 1

/* tlu_controller_core.f */
logic/tlu_pkg.sv
logic/tlu_cfg_if.sv
logic/tlu_reg_bank.sv
logic/tlu_trigger_input.sv
logic/tlu_trigger_counter.sv
logic/tlu_trigger_fsm.sv
logic/tlu_data_fifo.sv
logic/tlu_controller_core.sv
bench/tlu_core_checker.sv
bench/tb_tlu_controller_core.sv
